//--- vwrite.f
design/vwrite_pkg.sv
design/vwrite_ctrl.sv
design/store_addr_gen.sv
design/vwrite_buffer.sv
design/buffer_reader.sv
design/burst_writer.sv
design/vwrite_top.sv
test/vwrite_asserts.sv
test/vwrite_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = vwrite_tb
FILELIST  = vwrite.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)

check: run
	@if grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/vwrite_tb.sv
`timescale 1ns/100ps

module vwrite_tb;

   localparam int BUF_ADDR_W = 6;
   localparam int LEN_W      = 8;
   localparam int NROWS      = 5;

   typedef struct {
      bit          pp;
      bit          en;
      int          start, per, duty, incr, shift, iter, delay, amount, length;
      logic [31:0] ext;
      logic [31:0] base;
   } row_t;

   logic clk, rst, run_i, done_o, ping_pong_i, enabled_i, databus_ready_i;
   logic [vwrite_pkg::DATA_W-1:0] in0_i, databus_wdata_o;
   logic [vwrite_pkg::AXI_ADDR_W-1:0] ext_addr_i, databus_addr_o;
   logic [BUF_ADDR_W-1:0] amount_minus_one_i, start_i, incr_i, shift_i, iter_i;
   logic [LEN_W-1:0] length_i, databus_len_o;
   logic [7:0] per_i, duty_i;
   logic [5:0] delay_i;
   logic databus_valid_o, databus_last_o;

   row_t rows [0:NROWS-1];
   row_t cur;
   logic [vwrite_pkg::DATA_W-1:0] model_mem [0:1][0:(2**BUF_ADDR_W)-1];
   logic [vwrite_pkg::DATA_W-1:0] exp_q [$];
   vwrite_pkg::bank_t model_bank;
   integer seed = 68;
   int mismatches = 0;
   int others = 0;
   int cycles = 0;
   int limit = 1000000;
   int widx;

   vwrite_top UUT (.*);

   initial clk = 1'b0;
   always #50 clk = ~clk;

   task automatic check_word(input string name, input logic [vwrite_pkg::DATA_W-1:0] got,
                             input logic [vwrite_pkg::DATA_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [vwrite_pkg::AXI_ADDR_W-1:0] got,
                             input logic [vwrite_pkg::AXI_ADDR_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_len(input string name, input logic [LEN_W-1:0] got,
                            input logic [LEN_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic set_row(input int i, input bit pp, input bit en, input int start,
                          input int per, input int duty, input int incr, input int shift,
                          input int iter, input int delay, input int amount,
                          input int length, input logic [31:0] ext, input logic [31:0] base);
      rows[i] = '{pp, en, start, per, duty, incr, shift, iter, delay, amount, length, ext, base};
   endtask

   // store rule applied to the model banks, then the words the run should send
   task automatic predict_run(input row_t r);
      int p;
      int k;
      int addr;
      vwrite_pkg::bank_t rb;
      model_bank = r.pp ? ~model_bank : 1'b0;
      rb = r.pp ? ~model_bank : 1'b0;
      // transfer words of the opposite bank are taken before this run's stores
      if (r.en && r.pp) begin
         for (int i = 0; i < r.amount; i++) exp_q.push_back(model_mem[rb][i]);
      end
      for (int n = 0; n < r.iter * r.per; n++) begin
         p = n / r.per;
         k = n % r.per;
         if (k < r.duty) begin
            addr = (r.start + p * r.shift + k * r.incr) % (2**BUF_ADDR_W);
            model_mem[model_bank][addr] = r.base + r.delay + n;
         end
      end
      if (r.en && !r.pp) begin
         for (int i = 0; i < r.amount; i++) exp_q.push_back(model_mem[rb][i]);
      end
   endtask

   // databus slave with random back-pressure
   always @(negedge clk) begin
      if (!rst) databus_ready_i <= (($random(seed) & 3) != 0);
   end

   always @(posedge clk) begin
      int first;
      int blen;
      if (!rst && databus_valid_o) begin
         if (exp_q.size() == 0) begin
            others++;
            $display("databus valid raised when no word was expected");
         end else if (databus_ready_i) begin
            first = (widx / cur.length) * cur.length;
            blen = (cur.amount - first < cur.length) ? cur.amount - first : cur.length;
            check_word("databus_wdata_o", databus_wdata_o, exp_q.pop_front());
            check_addr("databus_addr_o", databus_addr_o, cur.ext + 4 * first);
            check_len("databus_len_o", databus_len_o, blen[LEN_W-1:0]);
            check_flag("databus_last_o", databus_last_o, (widx - first) == blen - 1);
            widx++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         others++;
         $display("timeout after %0d cycles, done never returned", cycles);
         $display("errors: %0d mismatches, %0d other failures", mismatches, others);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      int t;
      int sum;
      rst = 1'b1;
      run_i = 1'b0;
      in0_i = '0;
      ping_pong_i = 1'b0;
      enabled_i = 1'b0;
      ext_addr_i = '0;
      amount_minus_one_i = '0;
      length_i = 8'd1;
      start_i = '0;
      per_i = 8'd1;
      duty_i = 8'd1;
      incr_i = '0;
      shift_i = '0;
      iter_i = 6'd1;
      delay_i = '0;
      databus_ready_i = 1'b0;
      model_bank = 1'b0;
      widx = 0;
      //      pp en st per duty incr shift iter delay amt len ext base
      set_row(0, 0, 1, 0, 4, 3, 1, 3, 4, 2, 12, 4, 32'h1000_0000, 32'h0000_0100);
      set_row(1, 1, 1, 0, 5, 5, 1, 5, 4, 3, 10, 4, 32'h2000_0040, 32'h0000_0200);
      set_row(2, 1, 1, 2, 3, 2, 2, 7, 5, 0, 20, 8, 32'h3000_0000, 32'h0000_0300);
      set_row(3, 1, 0, 5, 4, 2, 1, 4, 3, 4, 8, 4, 32'h4000_0000, 32'h0000_0400);
      set_row(4, 0, 1, 60, 8, 8, 1, 8, 2, 1, 12, 5, 32'h5000_0100, 32'h0000_0500);
      sum = 0;
      foreach (rows[i]) sum += rows[i].delay + rows[i].iter * rows[i].per + 4 * rows[i].amount;
      limit = sum + 200;

      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      check_flag("done_o", done_o, 1'b1);

      for (int r = 0; r < NROWS; r++) begin
         cur = rows[r];
         widx = 0;
         predict_run(cur);
         ping_pong_i = cur.pp;
         enabled_i = cur.en;
         ext_addr_i = cur.ext;
         amount_minus_one_i = cur.amount - 1;
         length_i = cur.length;
         start_i = cur.start;
         per_i = cur.per;
         duty_i = cur.duty;
         incr_i = cur.incr;
         shift_i = cur.shift;
         iter_i = cur.iter;
         delay_i = cur.delay;
         run_i = 1'b1;
         t = 0;
         @(negedge clk);
         run_i = 1'b0;
         check_flag("done_o", done_o, 1'b0);
         // stream word follows the cycle count of the run
         while (!done_o) begin
            in0_i = cur.base + t;
            t++;
            @(negedge clk);
         end
         if (exp_q.size() != 0) begin
            others++;
            $display("run %0d finished with %0d words not sent", r, exp_q.size());
            exp_q.delete();
         end
         @(negedge clk);
      end

      $display("errors: %0d mismatches, %0d other failures", mismatches, others);
      if (mismatches == 0 && others == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- test/vwrite_asserts.sv
`timescale 1ns/100ps

module vwrite_asserts #(
   parameter int LEN_W = 8
) (
   input logic                              clk,
   input logic                              rst,
   input logic                              databus_valid_o,
   input logic                              databus_ready_i,
   input logic [vwrite_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   input logic [    vwrite_pkg::DATA_W-1:0] databus_wdata_o,
   input logic                              databus_last_o,
   input logic [               LEN_W-1:0] databus_len_o,
   input logic                              done_o
);

   logic [LEN_W-1:0] beats_seen;

   // beats already moved in the open burst
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         beats_seen <= '0;
      end else if (databus_valid_o && databus_ready_i) begin
         beats_seen <= databus_last_o ? '0 : beats_seen + 1'b1;
      end
   end

   // valid holds with its beat until ready
   valid_hold: assert property (@(posedge clk) disable iff (rst)
      databus_valid_o && !databus_ready_i |=>
         databus_valid_o && $stable(databus_addr_o) && $stable(databus_wdata_o))
      else $error("databus valid dropped or address changed before ready");

   last_on_final: assert property (@(posedge clk) disable iff (rst)
      databus_valid_o |-> databus_last_o == ((beats_seen + 1'b1) == databus_len_o))
      else $error("databus last away from the final beat of a burst");

   // writer idle when reset is released
   idle_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !databus_valid_o && !done_o)
      else $error("burst writer busy right after reset");

endmodule

bind burst_writer vwrite_asserts #(.LEN_W(LEN_W)) u_asserts (
   .clk            (clk),
   .rst            (rst),
   .databus_valid_o(databus_valid_o),
   .databus_ready_i(databus_ready_i),
   .databus_addr_o (databus_addr_o),
   .databus_wdata_o(databus_wdata_o),
   .databus_last_o (databus_last_o),
   .databus_len_o  (databus_len_o),
   .done_o         (done_o)
);

//--- design/vwrite_top.sv
`timescale 1ns/100ps

module vwrite_top #(
   parameter int BUF_ADDR_W = 6,
   parameter int PERIOD_W   = 8,
   parameter int LEN_W      = 8,
   parameter int DELAY_W    = 6
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run_i,
   output logic                              done_o,
   input  logic [    vwrite_pkg::DATA_W-1:0] in0_i,
   input  logic                              ping_pong_i,
   input  logic                              enabled_i,
   input  logic [vwrite_pkg::AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [          BUF_ADDR_W-1:0] amount_minus_one_i,
   input  logic [               LEN_W-1:0] length_i,
   input  logic [          BUF_ADDR_W-1:0] start_i,
   input  logic [            PERIOD_W-1:0] per_i,
   input  logic [            PERIOD_W-1:0] duty_i,
   input  logic [          BUF_ADDR_W-1:0] incr_i,
   input  logic [          BUF_ADDR_W-1:0] shift_i,
   input  logic [          BUF_ADDR_W-1:0] iter_i,
   input  logic [             DELAY_W-1:0] delay_i,
   output logic                              databus_valid_o,
   input  logic                              databus_ready_i,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   output logic [               LEN_W-1:0] databus_len_o,
   output logic [    vwrite_pkg::DATA_W-1:0] databus_wdata_o,
   output logic                              databus_last_o
);

   logic                              store_start;
   logic                              xfer_start;
   logic                              store_done;
   logic                              xfer_done;
   vwrite_pkg::bank_t                 store_bank;
   vwrite_pkg::bank_t                 read_bank;
   logic                              store_en;
   logic [          BUF_ADDR_W-1:0] store_addr;
   logic                              rd_en;
   logic [          BUF_ADDR_W-1:0] rd_addr;
   logic [    vwrite_pkg::DATA_W-1:0] rd_data;
   logic                              word_valid;
   logic                              word_ready;
   logic [    vwrite_pkg::DATA_W-1:0] word_data;
   logic [            BUF_ADDR_W:0] amount;
   logic [vwrite_pkg::AXI_ADDR_W-1:0] amount_ext;

   assign amount     = {1'b0, amount_minus_one_i} + 1'b1;
   assign amount_ext = {{(vwrite_pkg::AXI_ADDR_W-BUF_ADDR_W-1){1'b0}}, amount};

   vwrite_ctrl u_ctrl (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .enabled_i    (enabled_i),
      .ping_pong_i  (ping_pong_i),
      .store_done_i (store_done),
      .xfer_done_i  (xfer_done),
      .store_start_o(store_start),
      .xfer_start_o (xfer_start),
      .done_o       (done_o),
      .store_bank_o (store_bank),
      .read_bank_o  (read_bank)
   );

   store_addr_gen #(
      .BUF_ADDR_W(BUF_ADDR_W),
      .PERIOD_W  (PERIOD_W),
      .DELAY_W   (DELAY_W)
   ) u_store_addr_gen (
      .clk         (clk),
      .rst         (rst),
      .start_i     (store_start),
      .start_addr_i(start_i),
      .per_i       (per_i),
      .duty_i      (duty_i),
      .incr_i      (incr_i),
      .shift_i     (shift_i),
      .iter_i      (iter_i),
      .delay_i     (delay_i),
      .store_en_o  (store_en),
      .store_addr_o(store_addr),
      .done_o      (store_done)
   );

   // stream word is written in the cycle of its pattern step
   vwrite_buffer #(
      .BUF_ADDR_W(BUF_ADDR_W)
   ) u_buffer (
      .clk      (clk),
      .wr_en_i  (store_en),
      .wr_bank_i(store_bank),
      .wr_addr_i(store_addr),
      .wr_data_i(in0_i),
      .rd_en_i  (rd_en),
      .rd_bank_i(read_bank),
      .rd_addr_i(rd_addr),
      .rd_data_o(rd_data)
   );

   buffer_reader #(
      .BUF_ADDR_W(BUF_ADDR_W)
   ) u_reader (
      .clk         (clk),
      .rst         (rst),
      .start_i     (xfer_start),
      .count_i     (amount),
      .rd_data_i   (rd_data),
      .word_ready_i(word_ready),
      .rd_en_o     (rd_en),
      .rd_addr_o   (rd_addr),
      .word_valid_o(word_valid),
      .word_data_o (word_data)
   );

   burst_writer #(
      .LEN_W(LEN_W)
   ) u_writer (
      .clk            (clk),
      .rst            (rst),
      .start_i        (xfer_start),
      .ext_addr_i     (ext_addr_i),
      .count_i        (amount_ext),
      .length_i       (length_i),
      .word_valid_i   (word_valid),
      .word_data_i    (word_data),
      .databus_ready_i(databus_ready_i),
      .word_ready_o   (word_ready),
      .databus_valid_o(databus_valid_o),
      .databus_addr_o (databus_addr_o),
      .databus_len_o  (databus_len_o),
      .databus_wdata_o(databus_wdata_o),
      .databus_last_o (databus_last_o),
      .done_o         (xfer_done)
   );

endmodule

//--- design/burst_writer.sv
`timescale 1ns/100ps

module burst_writer #(
   parameter int LEN_W = 8
) (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              start_i,
   input  logic [vwrite_pkg::AXI_ADDR_W-1:0] ext_addr_i,
   input  logic [vwrite_pkg::AXI_ADDR_W-1:0] count_i,
   input  logic [               LEN_W-1:0] length_i,
   input  logic                              word_valid_i,
   input  logic [    vwrite_pkg::DATA_W-1:0] word_data_i,
   input  logic                              databus_ready_i,
   output logic                              word_ready_o,
   output logic                              databus_valid_o,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   output logic [               LEN_W-1:0] databus_len_o,
   output logic [    vwrite_pkg::DATA_W-1:0] databus_wdata_o,
   output logic                              databus_last_o,
   output logic                              done_o
);

   logic                              active;
   logic                              in_burst;
   logic [vwrite_pkg::AXI_ADDR_W-1:0] remaining;
   logic [vwrite_pkg::AXI_ADDR_W-1:0] next_addr;
   logic [               LEN_W-1:0] beat_cnt;
   logic [               LEN_W-1:0] burst_len;
   logic [vwrite_pkg::AXI_ADDR_W-1:0] len_ext;
   logic                              beat;

   assign len_ext   = {{(vwrite_pkg::AXI_ADDR_W-LEN_W){1'b0}}, length_i};
   // final burst is cut to the words left
   assign burst_len = (remaining < len_ext) ? remaining[LEN_W-1:0] : length_i;

   assign word_ready_o    = databus_ready_i && in_burst;
   assign databus_valid_o = word_valid_i && in_burst;
   assign databus_wdata_o = word_data_i;
   assign databus_last_o  = in_burst && (beat_cnt == databus_len_o - 1'b1);

   assign beat   = databus_valid_o && databus_ready_i;
   assign done_o = beat && databus_last_o &&
                   (remaining == {{(vwrite_pkg::AXI_ADDR_W-LEN_W){1'b0}}, databus_len_o});

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active   <= 1'b0;
         in_burst <= 1'b0;
         beat_cnt <= '0;
      end else if (start_i) begin
         active   <= 1'b1;
         in_burst <= 1'b0;
      end else if (active && !in_burst) begin
         in_burst <= 1'b1;
         beat_cnt <= '0;
      end else if (beat) begin
         beat_cnt <= beat_cnt + 1'b1;
         if (databus_last_o) begin
            in_burst <= 1'b0;
            active   <= !done_o;
         end
      end
   end

   // burst address and length hold while the burst is open
   always_ff @(posedge clk) begin
      if (start_i) begin
         remaining <= count_i;
         next_addr <= ext_addr_i;
      end else if (active && !in_burst) begin
         databus_addr_o <= next_addr;
         databus_len_o  <= burst_len;
      end else if (beat && databus_last_o) begin
         remaining <= remaining - {{(vwrite_pkg::AXI_ADDR_W-LEN_W){1'b0}}, databus_len_o};
         next_addr <= next_addr + {{(vwrite_pkg::AXI_ADDR_W-LEN_W-2){1'b0}}, databus_len_o, 2'b00};
      end
   end

endmodule

//--- design/buffer_reader.sv
`timescale 1ns/100ps

module buffer_reader #(
   parameter int BUF_ADDR_W = 6
) (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          start_i,
   input  logic [          BUF_ADDR_W:0] count_i,
   input  logic [vwrite_pkg::DATA_W-1:0] rd_data_i,
   input  logic                          word_ready_i,
   output logic                          rd_en_o,
   output logic [        BUF_ADDR_W-1:0] rd_addr_o,
   output logic                          word_valid_o,
   output logic [vwrite_pkg::DATA_W-1:0] word_data_o
);

   logic                          active;
   logic [          BUF_ADDR_W:0] rd_cnt;
   logic                          pend;
   logic                          skid_valid;
   logic [vwrite_pkg::DATA_W-1:0] skid_data;
   logic                          pop;

   assign pop       = word_valid_o && word_ready_i;
   assign rd_addr_o = rd_cnt[BUF_ADDR_W-1:0];

   // no new read if the returning word would have nowhere to go
   assign rd_en_o = active && !skid_valid && !(word_valid_o && pend && !pop);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active       <= 1'b0;
         rd_cnt       <= '0;
         pend         <= 1'b0;
         word_valid_o <= 1'b0;
         skid_valid   <= 1'b0;
      end else begin
         pend <= rd_en_o;
         if (start_i) begin
            active <= 1'b1;
            rd_cnt <= '0;
         end else if (rd_en_o) begin
            rd_cnt <= rd_cnt + 1'b1;
            if (rd_cnt + 1'b1 == count_i) begin
               active <= 1'b0;
            end
         end
         if (!word_valid_o || pop) begin
            word_valid_o <= skid_valid || pend;
            skid_valid   <= skid_valid && pend;
         end else if (pend) begin
            skid_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!word_valid_o || pop) begin
         if (skid_valid) begin
            word_data_o <= skid_data;
            skid_data   <= rd_data_i;
         end else begin
            word_data_o <= rd_data_i;
         end
      end else if (pend) begin
         skid_data <= rd_data_i;
      end
   end

endmodule

//--- design/vwrite_buffer.sv
`timescale 1ns/100ps

module vwrite_buffer #(
   parameter int BUF_ADDR_W = 6
) (
   input  logic                          clk,
   input  logic                          wr_en_i,
   input  vwrite_pkg::bank_t             wr_bank_i,
   input  logic [        BUF_ADDR_W-1:0] wr_addr_i,
   input  logic [vwrite_pkg::DATA_W-1:0] wr_data_i,
   input  logic                          rd_en_i,
   input  vwrite_pkg::bank_t             rd_bank_i,
   input  logic [        BUF_ADDR_W-1:0] rd_addr_i,
   output logic [vwrite_pkg::DATA_W-1:0] rd_data_o
);

   // bank index is the top address bit
   logic [vwrite_pkg::DATA_W-1:0] mem [0:(2**(BUF_ADDR_W+1))-1];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[{wr_bank_i, wr_addr_i}] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_o <= mem[{rd_bank_i, rd_addr_i}];
      end
   end

endmodule

//--- design/store_addr_gen.sv
`timescale 1ns/100ps

module store_addr_gen #(
   parameter int BUF_ADDR_W = 6,
   parameter int PERIOD_W   = 8,
   parameter int DELAY_W    = 6
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  start_i,
   input  logic [BUF_ADDR_W-1:0] start_addr_i,
   input  logic [  PERIOD_W-1:0] per_i,
   input  logic [  PERIOD_W-1:0] duty_i,
   input  logic [BUF_ADDR_W-1:0] incr_i,
   input  logic [BUF_ADDR_W-1:0] shift_i,
   input  logic [BUF_ADDR_W-1:0] iter_i,
   input  logic [   DELAY_W-1:0] delay_i,
   output logic                  store_en_o,
   output logic [BUF_ADDR_W-1:0] store_addr_o,
   output logic                  done_o
);

   logic                  busy;
   logic [   DELAY_W-1:0] delay_cnt;
   logic [  PERIOD_W-1:0] per_cnt;
   logic [BUF_ADDR_W-1:0] iter_cnt;
   logic [BUF_ADDR_W-1:0] addr;
   logic [BUF_ADDR_W-1:0] row_addr;
   logic                  stepping;
   logic                  per_end;

   // one pattern step per cycle once the delay has run out
   assign stepping = busy && (delay_cnt == '0);
   assign per_end  = ({1'b0, per_cnt} + 1'b1) >= {1'b0, per_i};

   assign store_en_o   = stepping && (iter_cnt != iter_i) && (per_cnt < duty_i);
   assign store_addr_o = addr;
   assign done_o       = stepping && (iter_cnt == iter_i);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy      <= 1'b0;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
      end else if (start_i) begin
         busy      <= 1'b1;
         delay_cnt <= delay_i;
         per_cnt   <= '0;
         iter_cnt  <= '0;
      end else if (busy && !stepping) begin
         delay_cnt <= delay_cnt - 1'b1;
      end else if (done_o) begin
         busy <= 1'b0;
      end else if (stepping) begin
         if (per_end) begin
            per_cnt  <= '0;
            iter_cnt <= iter_cnt + 1'b1;
         end else begin
            per_cnt <= per_cnt + 1'b1;
         end
      end
   end

   // running address wraps at the bank size
   always_ff @(posedge clk) begin
      if (start_i) begin
         addr     <= start_addr_i;
         row_addr <= start_addr_i;
      end else if (stepping && !done_o) begin
         if (per_end) begin
            addr     <= row_addr + shift_i;
            row_addr <= row_addr + shift_i;
         end else begin
            addr <= addr + incr_i;
         end
      end
   end

endmodule

//--- design/vwrite_ctrl.sv
`timescale 1ns/100ps

module vwrite_ctrl (
   input  logic              clk,
   input  logic              rst,
   input  logic              run_i,
   input  logic              enabled_i,
   input  logic              ping_pong_i,
   input  logic              store_done_i,
   input  logic              xfer_done_i,
   output logic              store_start_o,
   output logic              xfer_start_o,
   output logic              done_o,
   output vwrite_pkg::bank_t store_bank_o,
   output vwrite_pkg::bank_t read_bank_o
);

   vwrite_pkg::ctrl_state_e state;
   vwrite_pkg::ctrl_state_e state_nxt;
   vwrite_pkg::bank_t       bank_q;
   logic                    accept;

   // a run is only taken while the unit reports done
   assign done_o        = (state == vwrite_pkg::IDLE) || (state == vwrite_pkg::DONE_WAIT);
   assign accept        = run_i && done_o;
   assign store_start_o = accept;

   assign store_bank_o = bank_q;
   assign read_bank_o  = ping_pong_i ? ~bank_q : 1'b0;

   always_comb begin
      state_nxt = state;
      case (state)
         vwrite_pkg::IDLE, vwrite_pkg::DONE_WAIT: begin
            if (!accept) begin
               state_nxt = vwrite_pkg::IDLE;
            end else if (ping_pong_i && enabled_i) begin
               state_nxt = vwrite_pkg::STORE_XFER;
            end else begin
               state_nxt = vwrite_pkg::STORE;
            end
         end
         vwrite_pkg::STORE: begin
            if (store_done_i) begin
               // without ping-pong the transfer follows the stores
               state_nxt = (enabled_i && !ping_pong_i) ? vwrite_pkg::XFER : vwrite_pkg::DONE_WAIT;
            end
         end
         vwrite_pkg::STORE_XFER: begin
            if (store_done_i && xfer_done_i) begin
               state_nxt = vwrite_pkg::DONE_WAIT;
            end else if (store_done_i) begin
               state_nxt = vwrite_pkg::XFER;
            end else if (xfer_done_i) begin
               state_nxt = vwrite_pkg::STORE;
            end
         end
         vwrite_pkg::XFER: begin
            if (xfer_done_i) begin
               state_nxt = vwrite_pkg::DONE_WAIT;
            end
         end
         default: begin
            state_nxt = vwrite_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state        <= vwrite_pkg::IDLE;
         bank_q       <= 1'b0;
         xfer_start_o <= 1'b0;
      end else begin
         state        <= state_nxt;
         xfer_start_o <= (accept && ping_pong_i && enabled_i) ||
                         (state == vwrite_pkg::STORE && store_done_i &&
                          enabled_i && !ping_pong_i);
         if (accept) begin
            bank_q <= ping_pong_i ? ~bank_q : 1'b0;
         end
      end
   end

endmodule

//--- design/vwrite_pkg.sv
package vwrite_pkg;

   // stream, buffer and databus word width
   localparam int DATA_W = 32;

   // external byte address width
   localparam int AXI_ADDR_W = 32;

   // run sequencing states
   typedef enum logic [2:0] {
      IDLE       = 3'd0,
      STORE      = 3'd1,
      STORE_XFER = 3'd2,
      XFER       = 3'd3,
      DONE_WAIT  = 3'd4
   } ctrl_state_e;

   // buffer bank index
   typedef logic bank_t;

endpackage
